// File: hw/cart_addr_xlate.sv
// Cartridge address translation
// Redirects CPU accesses in ROML, ROMH and IO2 to the image memory
// and derives the memory write and chip enable for the access

`timescale 1ns/100ps

module cart_addr_xlate (
	input  logic                rom_l,
	input  logic                rom_h,
	input  logic                iof,
	input  logic                mem_write,
	input  logic                mem_ce,
	input  cart_cfg_pkg::addr_t addr_in,
	cart_map_if.xlate           map,
	output cart_cfg_pkg::addr_t addr_out,
	output logic                mem_write_out,
	output logic                mem_ce_out
);
	import cart_cfg_pkg::*;

	logic cs_iof;   // IO2 lands in cart RAM
	logic ultimax;

	assign cs_iof  = iof && (mem_write ? map.iof_wr_ena : map.iof_ena);
	assign ultimax = map.exrom && !map.game;

	// ******************************************************************
	// Memory control
	// ******************************************************************

	// IO2 access gets its own enable pulse
	assign mem_ce_out = mem_ce | (cs_iof & map.iof_stb);

	// No RAM under ROML in ultimax mode
	assign mem_write_out = mem_write & ~(rom_l & ultimax);

	// ******************************************************************
	// Address redirection
	// ******************************************************************
	always_comb begin
		addr_out = addr_in;

		// ROM windows are read only, writes go through to RAM
		if (rom_h && !mem_write)
			addr_out[PAGE_LSB+BANK_W:PAGE_LSB] = {ROM_BASE_BIT, map.bank_hi};
		if (rom_l && !mem_write)
			addr_out[PAGE_LSB+BANK_W:PAGE_LSB] = {ROM_BASE_BIT, map.bank_lo};

		if (cs_iof)
			addr_out[PAGE_LSB+BANK_W:PAGE_LSB] = RAM_PAGE;  // Cart RAM page
	end

endmodule

// File: hw/cart_bank_table.sv
// Cartridge bank table
// Records where each CRT chip packet sits in the image memory, as a
// low and a high 8K bank per bank number, and counts the packets loaded

`timescale 1ns/100ps

module cart_bank_table (
	input  logic                   clk32,
	input  logic                   reset_n,
	input  logic                   cart_loading,
	input  logic                   bank_wr,
	input  logic            [15:0] bank_num,
	input  logic            [15:0] bank_laddr,   // Packet load address
	input  logic            [15:0] bank_size,
	input  cart_cfg_pkg::addr_t     bank_raddr,   // Packet location in memory
	input  cart_cfg_pkg::bank_idx_t lookup_idx,
	output cart_cfg_pkg::bank_t     lo_bank,
	output cart_cfg_pkg::bank_t     hi_bank,
	output cart_cfg_pkg::bank_cnt_t bank_count
);
	import cart_cfg_pkg::*;

	bank_t     lo_banks [NUM_BANKS];
	bank_t     hi_banks [NUM_BANKS];
	logic      loading_d;
	bank_t     raddr_bank;
	bank_idx_t wr_idx;

	assign raddr_bank = bank_raddr[PAGE_LSB+BANK_W-1:PAGE_LSB];  // Bits 19:13
	assign wr_idx     = bank_num[$bits(bank_idx_t)-1:0];

	// ******************************************************************
	// Table write
	// ******************************************************************
	always_ff @(posedge clk32) begin
		if (bank_wr && bank_num < 16'(NUM_BANKS)) begin
			if (bank_laddr <= TABLE_LOAD_LIMIT) begin
				lo_banks[wr_idx] <= raddr_bank;
				// 16K packet also covers ROMH
				if (bank_size > LO_SIZE_LIMIT)
					hi_banks[wr_idx] <= raddr_bank + 1'b1;
			end else begin
				hi_banks[wr_idx] <= raddr_bank;
			end
		end
	end

	// Loaded bank counter, restarted when a new image begins
	always_ff @(posedge clk32) begin
		if (reset_n) begin
			loading_d  <= 1'b0;
			bank_count <= '0;
		end else begin
			loading_d <= cart_loading;
			if (cart_loading && !loading_d)
				bank_count <= '0;
			if (bank_wr)
				bank_count <= bank_count + 1'b1;  // Out of range banks count too
		end
	end

	assign lo_bank = lo_banks[lookup_idx];
	assign hi_bank = hi_banks[lookup_idx];

endmodule

// File: hw/cart_cfg_pkg.sv
// Cartridge mapper configuration
// Memory widths, the image address layout and the bank table limits
// shared by the mapper blocks

package cart_cfg_pkg;

	// ******************************************************************
	// Widths
	// ******************************************************************
	localparam int ADDR_W     = 25;  // External memory address
	localparam int BANK_W     = 7;
	localparam int NUM_BANKS  = 64;  // Bank table entries
	localparam int BANK_CNT_W = 8;

	// Address layout of the image memory
	localparam int         PAGE_LSB     = 13;     // 8K pages
	localparam logic       ROM_BASE_BIT = 1'b1;   // ROM banks at 0x100000
	localparam logic [7:0] RAM_PAGE     = 8'h08;  // Cart RAM at 0x010000

	// CRT chip packet limits
	localparam logic [15:0] TABLE_LOAD_LIMIT = 16'h8000;
	localparam logic [15:0] LO_SIZE_LIMIT    = 16'h2000;

	// EasyFlash control register offset in IO1
	localparam logic [1:0] EF_CTRL_REG = 2'd2;

	typedef logic [ADDR_W-1:0]     addr_t;
	typedef logic [BANK_W-1:0]     bank_t;
	typedef logic [5:0]            bank_idx_t;
	typedef logic [BANK_CNT_W-1:0] bank_cnt_t;

endpackage

// File: hw/cart_map_if.sv
// Cartridge mapping state
// Carries the bank, line and IO2 state from the mapper control
// to the address translator

`timescale 1ns/100ps

interface cart_map_if;
	import cart_cfg_pkg::*;

	bank_t bank_lo;     // Bank seen in ROML
	bank_t bank_hi;     // Bank seen in ROMH
	logic  exrom;
	logic  game;
	logic  iof_ena;     // IO2 reads go to cart RAM
	logic  iof_wr_ena;  // IO2 writes go to cart RAM
	logic  ioe_stb;
	logic  iof_stb;

	modport ctrl (
		output bank_lo, bank_hi, exrom, game,
		output iof_ena, iof_wr_ena, ioe_stb, iof_stb
	);

	modport xlate (
		input bank_lo, bank_hi, exrom, game,
		input iof_ena, iof_wr_ena, ioe_stb, iof_stb
	);

endinterface

// File: hw/cart_mapper_ctrl.sv
// Cartridge mapper control
// Tracks the bank registers and the EXROM/GAME lines for the selected
// cartridge type. IO1/IO2 accesses are turned into strobes and applied
// by the per-type rules. A reset or a new cart id runs one init cycle.

`timescale 1ns/100ps

module cart_mapper_ctrl (
	input  logic                                 clk32,
	input  logic                                 reset_n,
	input  logic [cart_type_pkg::CART_ID_W-1:0]  cart_id,
	input  logic                           [7:0] cart_exrom,  // CRT header EXROM
	input  logic                           [7:0] cart_game,   // CRT header GAME
	input  logic                                 ioe,
	input  logic                                 iof,
	input  logic                                 mem_write,
	input  cart_cfg_pkg::addr_t                  addr_in,
	input  logic                           [7:0] data_in,
	input  cart_cfg_pkg::bank_t                  lo_bank,
	input  cart_cfg_pkg::bank_t                  hi_bank,
	input  cart_cfg_pkg::bank_cnt_t              bank_count,
	output cart_cfg_pkg::bank_idx_t              lookup_idx,
	cart_map_if.ctrl                             map
);
	import cart_cfg_pkg::*;
	import cart_type_pkg::*;

	cart_type_e                 cart_type;
	logic [CART_ID_W-1:0]       old_id;
	logic                       init_n;       // Low on the init cycle
	logic                       ioe_d;
	logic                       iof_d;
	logic                       ioe_wr;
	logic                       ioe_rd;
	logic                       is_ef;
	bank_t                      md_bank;

	assign cart_type = cart_type_of(cart_id);
	assign is_ef     = (cart_type == CART_EASYFLASH) || (cart_type == CART_EASYFLASH_X);

	// ******************************************************************
	// IO1/IO2 edge detect
	// ******************************************************************
	always_ff @(posedge clk32) begin
		if (reset_n) begin
			ioe_d       <= 1'b0;
			iof_d       <= 1'b0;
			map.ioe_stb <= 1'b0;
			map.iof_stb <= 1'b0;
		end else begin
			ioe_d       <= ioe;
			iof_d       <= iof;
			map.ioe_stb <= ioe && !ioe_d;
			map.iof_stb <= iof && !iof_d;
		end
	end

	assign ioe_wr = map.ioe_stb && mem_write;
	assign ioe_rd = map.ioe_stb && !mem_write;

	// EasyFlash bank write picks its table entry, others use entry 0
	assign lookup_idx = (is_ef && ioe_wr) ? data_in[5:0] : '0;

	// Magic Desk bank width follows the image size
	always_comb begin
		if (bank_count <= 8'd16)      md_bank = {3'b000, data_in[3:0]};
		else if (bank_count <= 8'd32) md_bank = {2'b00, data_in[4:0]};
		else if (bank_count <= 8'd64) md_bank = {1'b0, data_in[5:0]};
		else                          md_bank = data_in[6:0];
	end

	// ******************************************************************
	// Per-type state
	// ******************************************************************
	always_ff @(posedge clk32) begin
		old_id <= cart_id;
		if (reset_n || old_id != cart_id) begin
			init_n         <= 1'b0;
			map.bank_lo    <= '0;
			map.bank_hi    <= '0;
			map.exrom      <= 1'b1;  // Empty slot
			map.game       <= 1'b1;
			map.iof_ena    <= 1'b0;
			map.iof_wr_ena <= 1'b0;
		end else begin
			init_n <= 1'b1;
			case (cart_type)
				CART_GENERIC: begin
					map.exrom   <= cart_exrom[0];
					map.game    <= cart_game[0];
					map.bank_lo <= lo_bank;
					map.bank_hi <= hi_bank;
				end
				CART_OCEAN: begin
					map.exrom <= 1'b0;
					map.game  <= 1'b0;
					if (ioe_wr) begin
						map.bank_lo <= {1'b0, data_in[5:0]};
						map.bank_hi <= {1'b0, data_in[5:0]};  // Mirrored in ROMH
					end
				end
				CART_C64GS: begin
					map.exrom <= 1'b0;
					map.game  <= 1'b1;
					if (ioe_rd) map.bank_lo <= '0;
					if (ioe_wr) map.bank_lo <= {1'b0, addr_in[5:0]};  // Bank in the address
				end
				CART_MAGIC_DESK: begin
					map.game <= 1'b1;
					if (!init_n) begin
						map.exrom   <= 1'b0;
						map.bank_lo <= '0;
					end else if (ioe_wr) begin
						map.bank_lo <= md_bank;
						map.exrom   <= data_in[7];  // Bit 7 hides the cart
					end
				end
				CART_EASYFLASH, CART_EASYFLASH_X: begin
					if (!init_n) begin
						map.iof_ena    <= 1'b1;
						map.iof_wr_ena <= 1'b1;
						map.exrom      <= (cart_type == CART_EASYFLASH);  // XBank skips ultimax
						map.game       <= 1'b0;
						map.bank_lo    <= lo_bank;
						map.bank_hi    <= hi_bank;
					end else if (ioe_wr) begin
						if (addr_in[1:0] == EF_CTRL_REG) begin
							map.game  <= ~data_in[0] & data_in[2];
							map.exrom <= ~data_in[1];
						end else begin
							map.bank_lo <= lo_bank;
							map.bank_hi <= hi_bank;
						end
					end
				end
				default: begin
					map.exrom <= 1'b1;
					map.game  <= 1'b1;
				end
			endcase
		end
	end

endmodule

// File: hw/cart_top.sv
// Cartridge mapper top level
// Bank table, mapper control and address translation in a chain,
// with plain ports toward the CPU bus and the image memory

`timescale 1ns/100ps

module cart_top (
	input  logic                                clk32,
	input  logic                                reset_n,
	input  logic                                cart_loading,
	input  logic [cart_type_pkg::CART_ID_W-1:0] cart_id,
	input  logic                          [7:0] cart_exrom,
	input  logic                          [7:0] cart_game,
	input  logic                         [15:0] cart_bank_laddr,
	input  logic                         [15:0] cart_bank_size,
	input  logic                         [15:0] cart_bank_num,
	input  cart_cfg_pkg::addr_t                 cart_bank_raddr,
	input  logic                                cart_bank_wr,
	input  logic                                rom_l,
	input  logic                                rom_h,
	input  logic                                ioe,
	input  logic                                iof,
	input  logic                                mem_write,
	input  logic                                mem_ce,
	input  cart_cfg_pkg::addr_t                 addr_in,
	input  logic                          [7:0] data_in,
	output logic                                exrom,
	output logic                                game,
	output logic                                mem_ce_out,
	output logic                                mem_write_out,
	output cart_cfg_pkg::addr_t                 addr_out
);

	cart_cfg_pkg::bank_idx_t lookup_idx;
	cart_cfg_pkg::bank_t     lo_bank;
	cart_cfg_pkg::bank_t     hi_bank;
	cart_cfg_pkg::bank_cnt_t bank_count;

	cart_map_if map_if ();

	cart_bank_table i_table (
		.clk32, .reset_n, .cart_loading,
		.bank_wr(cart_bank_wr), .bank_num(cart_bank_num), .bank_laddr(cart_bank_laddr),
		.bank_size(cart_bank_size), .bank_raddr(cart_bank_raddr),
		.lookup_idx, .lo_bank, .hi_bank, .bank_count
	);

	cart_mapper_ctrl i_ctrl (
		.clk32, .reset_n, .cart_id, .cart_exrom, .cart_game, .ioe, .iof, .mem_write,
		.addr_in, .data_in, .lo_bank, .hi_bank, .bank_count, .lookup_idx, .map(map_if.ctrl)
	);

	cart_addr_xlate i_xlate (
		.rom_l, .rom_h, .iof, .mem_write, .mem_ce, .addr_in, .map(map_if.xlate),
		.addr_out, .mem_write_out, .mem_ce_out
	);

	assign exrom = map_if.exrom;
	assign game  = map_if.game;

endmodule

// File: hw/cart_type_pkg.sv
// Cartridge type definitions
// Supported hardware types and the decode of the CRT hardware id

package cart_type_pkg;

	localparam int CART_ID_W = 16;

	typedef enum logic [2:0] {
		CART_GENERIC,
		CART_OCEAN,
		CART_C64GS,
		CART_MAGIC_DESK,
		CART_EASYFLASH,
		CART_EASYFLASH_X,
		CART_UNSUPPORTED  // Acts as an empty slot
	} cart_type_e;

	function automatic cart_type_e cart_type_of(input logic [CART_ID_W-1:0] id);
		case (id)
			16'd0:   return CART_GENERIC;
			16'd5:   return CART_OCEAN;
			16'd15:  return CART_C64GS;
			16'd19:  return CART_MAGIC_DESK;
			16'd32:  return CART_EASYFLASH;
			16'd33:  return CART_EASYFLASH_X;  // XBank layout
			default: return CART_UNSUPPORTED;
		endcase
	endfunction

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the cartridge mapper testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_cart -f src.f -o tb_cart_sim
output=$(./obj_dir/tb_cart_sim 2>&1)
echo "$output"

if grep -qFx "Done: no errors" <<< "$output"; then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi

// File: sim/cart_sva.sv
// Cartridge mapper assertions
// Checks the reset state of the lines, the write gating and the
// upper address bits that translation must leave alone

`timescale 1ns/100ps

module cart_sva (
	input logic                clk32,
	input logic                reset_n,
	input logic                exrom,
	input logic                game,
	input logic                mem_write,
	input logic                mem_write_out,
	input cart_cfg_pkg::addr_t addr_in,
	input cart_cfg_pkg::addr_t addr_out
);
	import cart_cfg_pkg::*;

	localparam int KEEP_LSB = PAGE_LSB + BANK_W + 1;  // First bit above the page field

	// Empty slot while held in reset
	reset_lines: assert property (@(posedge clk32) reset_n |=> (exrom && game))
		else $error("exrom and game not both high during reset");

	write_gate: assert property (@(posedge clk32) !(mem_write_out && !mem_write))
		else $error("mem_write_out high without mem_write");

	upper_addr: assert property (@(posedge clk32)
		addr_out[ADDR_W-1:KEEP_LSB] == addr_in[ADDR_W-1:KEEP_LSB])
		else $error("addr_out upper bits differ from addr_in");

endmodule

bind cart_top cart_sva i_sva (
	.clk32, .reset_n, .exrom, .game,
	.mem_write, .mem_write_out, .addr_in, .addr_out
);

// File: sim/cart_trace.txt
# Columns (hex): LOAD num laddr size raddr count | TYPE id crt_exrom crt_game exrom game
# IO sel wr addr data | ACC win wr ce addr_in addr_out mem_write_out mem_ce_out | LINES exrom game
LOAD 0 8000 2000 104000 1
LOAD 0 a000 2000 106000 1
TYPE 0 0 0 0 0
LINES 0 0
ACC ROML 0 1 008123 104123 0 1
ACC ROMH 0 1 00a456 106456 0 1
ACC ROML 1 1 008123 008123 1 1
TYPE 5 0 0 0 0
IO IO1 1 00de00 15
ACC ROML 0 1 008010 12a010 0 1
ACC ROMH 0 1 00a020 12a020 0 1
TYPE f 0 0 0 1
IO IO1 1 00de07 00
ACC ROML 0 1 008100 10e100 0 1
IO IO1 0 00de00 00
ACC ROML 0 1 008100 100100 0 1
LOAD 0 8000 2000 100000 10
TYPE 13 0 0 0 1
IO IO1 1 00de00 1f
ACC ROML 0 1 008200 11e200 0 1
TYPE 13 0 0 0 1
LOAD 0 8000 2000 100000 40
IO IO1 1 00de00 1f
ACC ROML 0 1 008200 13e200 0 1
IO IO1 1 00de00 9f
LINES 1 1
LOAD 0 8000 4000 140000 1
LOAD 5 8000 4000 150000 1
TYPE 20 0 0 1 0
ACC ROML 0 1 008300 140300 0 1
ACC ROML 1 1 008300 008300 0 1
ACC IO2 0 0 00df10 011f10 0 1
IO IO1 1 00de02 04
LINES 1 1
IO IO1 1 00de00 05
ACC ROML 0 1 008300 150300 0 1
ACC ROMH 0 1 00a300 152300 0 1
TYPE 5 0 0 0 0
ACC ROML 0 1 008300 100300 0 1
ACC IO2 0 0 00df10 00df10 0 0
TYPE 21 0 0 0 0
ACC ROML 0 1 008300 140300 0 1
ACC IO2 0 0 00df10 011f10 0 1

// File: sim/tb_cart.sv
// Cartridge mapper testbench
// Replays the trace file against the mapper top level: bank table
// loads, type changes, IO1/IO2 register accesses and checked accesses
// to the ROML, ROMH and IO2 windows

`timescale 1ns/100ps

module tb_cart;
	import cart_cfg_pkg::*;
	import cart_type_pkg::*;

	localparam int    SETTLE_TIMEOUT = 16;  // Cycles for the lines to settle
	localparam string TRACE_FILE     = "sim/cart_trace.txt";

	logic                 clk32;
	logic                 reset_n;
	logic                 cart_loading;
	logic [CART_ID_W-1:0] cart_id;
	logic [7:0]           cart_exrom;
	logic [7:0]           cart_game;
	logic [15:0]          cart_bank_laddr;
	logic [15:0]          cart_bank_size;
	logic [15:0]          cart_bank_num;
	addr_t                cart_bank_raddr;
	logic                 cart_bank_wr;
	logic                 rom_l;
	logic                 rom_h;
	logic                 ioe;
	logic                 iof;
	logic                 mem_write;
	logic                 mem_ce;
	addr_t                addr_in;
	logic [7:0]           data_in;
	logic                 exrom;
	logic                 game;
	logic                 mem_ce_out;
	logic                 mem_write_out;
	addr_t                addr_out;

	int   checks;
	int   errors;    // Wrong values
	int   failures;  // Timeouts and trace problems
	logic aborted;

	cart_top i_dut (.*);

	initial begin
		clk32 = 1'b0;
		forever #10 clk32 = ~clk32;
	end

	// **********************************************************************
	// Compare tasks
	// **********************************************************************
	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_line(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic reject_line(input string why);
		failures++;
		aborted = 1'b1;
		$display("Trace stopped: %s", why);
	endtask

	// **********************************************************************
	// Trace steps
	// **********************************************************************

	// Packets advance by one bank number and one 8K page each
	task automatic load_packets(input logic [15:0] num, input logic [15:0] laddr,
			input logic [15:0] size, input addr_t raddr, input int count);
		if (!cart_loading) begin
			@(posedge clk32);
			cart_loading <= 1'b1;  // New image, bank count restarts
		end
		for (int i = 0; i < count; i++) begin
			@(posedge clk32);
			cart_bank_wr    <= 1'b1;
			cart_bank_num   <= num + 16'(i);
			cart_bank_laddr <= laddr;
			cart_bank_size  <= size;
			cart_bank_raddr <= raddr + (addr_t'(i) << PAGE_LSB);
		end
		@(posedge clk32);
		cart_bank_wr <= 1'b0;
	endtask

	task automatic select_type(input logic [CART_ID_W-1:0] id, input logic [7:0] crt_exrom,
			input logic [7:0] crt_game, input logic exp_exrom, input logic exp_game);
		int cycles;
		@(posedge clk32);
		cart_id      <= id;
		cart_exrom   <= crt_exrom;
		cart_game    <= crt_game;
		cart_loading <= 1'b0;         // Image complete
		repeat (2) @(posedge clk32);  // Init cycle, then type defaults
		@(negedge clk32);
		cycles = 0;
		while (exrom !== exp_exrom || game !== exp_game) begin
			if (cycles == SETTLE_TIMEOUT) begin
				failures++;
				aborted = 1'b1;
				$display("Lines did not settle to exrom %0d game %0d after type 0x%h",
					exp_exrom, exp_game, id);
				return;
			end
			cycles++;
			@(negedge clk32);
		end
		checks++;
	endtask

	task automatic io_access(input logic is_io2, input logic wr, input addr_t addr,
			input logic [7:0] data);
		@(posedge clk32);
		addr_in   <= addr;
		data_in   <= data;
		mem_write <= wr;
		ioe       <= !is_io2;
		iof       <= is_io2;
		repeat (3) @(posedge clk32);  // Edge register, state register, margin
		ioe       <= 1'b0;
		iof       <= 1'b0;
		mem_write <= 1'b0;
	endtask

	// Window 0 is ROML, 1 is ROMH, 2 is IO2
	task automatic window_access(input int win, input logic wr, input logic ce,
			input addr_t addr, input addr_t exp_addr, input logic exp_wr, input logic exp_ce);
		@(posedge clk32);
		rom_l     <= (win == 0);
		rom_h     <= (win == 1);
		iof       <= (win == 2);
		mem_write <= wr;
		mem_ce    <= ce;
		addr_in   <= addr;
		@(posedge clk32);  // IO2 strobe registers here
		@(negedge clk32);
		check_addr("addr_out", addr_out, exp_addr);
		check_line("mem_write_out", mem_write_out, exp_wr);
		check_line("mem_ce_out", mem_ce_out, exp_ce);
		@(posedge clk32);
		rom_l     <= 1'b0;
		rom_h     <= 1'b0;
		iof       <= 1'b0;
		mem_write <= 1'b0;
		mem_ce    <= 1'b0;
	endtask

	task automatic run_trace();
		int                   fd;
		int                   n;
		int                   win;
		logic [63:0]          kw;
		logic [63:0]          sel;
		logic [8*160-1:0]     rest;
		logic [15:0]          num;
		logic [15:0]          laddr;
		logic [15:0]          size;
		logic [15:0]          count;
		logic [CART_ID_W-1:0] id;
		logic [7:0]           crt_exrom;
		logic [7:0]           crt_game;
		logic [7:0]           data;
		logic                 ex;
		logic                 gm;
		logic                 wr;
		logic                 ce;
		logic                 exp_wr;
		logic                 exp_ce;
		addr_t                addr;
		addr_t                exp_addr;
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0) begin
			reject_line("the trace file could not be opened");
			return;
		end
		while (!aborted && $fscanf(fd, "%s", kw) == 1) begin
			if (kw == "#") begin
				n = $fgets(rest, fd);
			end else if (kw == "LOAD") begin
				n = $fscanf(fd, "%h %h %h %h %h", num, laddr, size, addr, count);
				if (n == 5) load_packets(num, laddr, size, addr, int'(count));
				else reject_line("a LOAD line is incomplete");
			end else if (kw == "TYPE") begin
				n = $fscanf(fd, "%h %h %h %h %h", id, crt_exrom, crt_game, ex, gm);
				if (n == 5) select_type(id, crt_exrom, crt_game, ex, gm);
				else reject_line("a TYPE line is incomplete");
			end else if (kw == "IO") begin
				n = $fscanf(fd, "%s %h %h %h", sel, wr, addr, data);
				if (n != 4 || (sel != "IO1" && sel != "IO2"))
					reject_line("an IO line is malformed");
				else
					io_access(sel == "IO2", wr, addr, data);
			end else if (kw == "ACC") begin
				n = $fscanf(fd, "%s %h %h %h %h %h %h", sel, wr, ce, addr, exp_addr,
					exp_wr, exp_ce);
				win = (sel == "ROML") ? 0 : (sel == "ROMH") ? 1 : (sel == "IO2") ? 2 : -1;
				if (n != 7 || win < 0)
					reject_line("an ACC line is malformed");
				else
					window_access(win, wr, ce, addr, exp_addr, exp_wr, exp_ce);
			end else if (kw == "LINES") begin
				n = $fscanf(fd, "%h %h", ex, gm);
				if (n == 2) begin
					@(negedge clk32);
					check_line("exrom", exrom, ex);
					check_line("game", game, gm);
				end else begin
					reject_line("a LINES line is incomplete");
				end
			end else begin
				reject_line("the trace holds an unknown keyword");
			end
		end
		$fclose(fd);
	endtask

	// **********************************************************************
	// Main sequence
	// **********************************************************************
	initial begin
		checks          = 0;
		errors          = 0;
		failures        = 0;
		aborted         = 1'b0;
		reset_n         = 1'b1;  // Active high
		cart_loading    = 1'b0;
		cart_id         = 16'hffff;  // No cart
		cart_exrom      = 8'h01;
		cart_game       = 8'h01;
		cart_bank_laddr = '0;
		cart_bank_size  = '0;
		cart_bank_num   = '0;
		cart_bank_raddr = '0;
		cart_bank_wr    = 1'b0;
		rom_l           = 1'b0;
		rom_h           = 1'b0;
		ioe             = 1'b0;
		iof             = 1'b0;
		mem_write       = 1'b0;
		mem_ce          = 1'b0;
		addr_in         = '0;
		data_in         = '0;
		repeat (10) @(posedge clk32);
		reset_n <= 1'b0;
		run_trace();
		if (checks == 0) begin
			failures++;
			$display("No checks ran");
		end
		$display("Checks: %0d, value errors: %0d, other failures: %0d",
			checks, errors, failures);
		if (errors == 0 && failures == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// File: src.f
hw/cart_cfg_pkg.sv
hw/cart_type_pkg.sv
hw/cart_map_if.sv
hw/cart_bank_table.sv
hw/cart_mapper_ctrl.sv
hw/cart_addr_xlate.sv
hw/cart_top.sv
sim/cart_sva.sv
sim/tb_cart.sv
